/* Makefile */
# Verilator build for the matrix multiply-accumulate unit
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= tb_mac_matrix_unit
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= *** TEST FAILED ***
PASS_MSG  ?= *** TEST PASSED ***

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation finished cleanly"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+tb
verilog/mac_pkg.sv
verilog/mac_decoder.sv
verilog/mac_lane_array.sv
verilog/mac_matmul_seq.sv
verilog/mac_writeback.sv
verilog/mac_matrix_unit.sv
tb/mac_assertions.sv
tb/tb_mac_matrix_unit.sv

/* tb/mac_assertions.sv */
`timescale 1ns/10ps

module mac_assertions
(
  input logic i_clk,
  input logic i_rst_n,
  input logic i_start,
  input logic i_abort,
  input logic i_busy,
  input logic i_done
);

  mac_pkg::mac_state_e exp_state;

  // Tracks whether an accepted start is still open
  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      exp_state <= mac_pkg::ST_IDLE;
    else if (i_abort)
      exp_state <= mac_pkg::ST_IDLE;
    else if (i_start && !i_busy)
      exp_state <= mac_pkg::ST_RUN;
    else if (i_done)
      exp_state <= mac_pkg::ST_IDLE;
  end

  a_idle_after_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_busy && !i_done)
    else $error("o_busy or o_done high right after reset");

  a_done_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_done |=> !i_done)
    else $error("o_done lasted more than one cycle");

  a_busy_falls_at_done: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_done |-> $fell(i_busy))
    else $error("o_busy did not fall together with o_done");

  a_done_needs_start: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_done |-> exp_state == mac_pkg::ST_RUN)
    else $error("o_done without an open start");

endmodule

bind mac_matrix_unit mac_assertions u_assertions (
  .i_clk   (i_clk),
  .i_rst_n (i_rst_n),
  .i_start (i_start),
  .i_abort (i_abort),
  .i_busy  (o_busy),
  .i_done  (o_done)
);

/* tb/mac_tb_model.svh */
`ifndef MAC_TB_MODEL_SVH
`define MAC_TB_MODEL_SVH

// ***************************************************************************
// Reference model, element (r,c) at bit (r*N_DIM + c)*SCALAR_W
// ***************************************************************************

function automatic logic [SCALAR_W-1:0] elem(input logic [MAT_W-1:0] m, input int r,
                                             input int c);
  return m[(r*N_DIM + c)*SCALAR_W +: SCALAR_W];
endfunction

function automatic logic [MAT_W-1:0] model_elementwise(input mac_pkg::mac_op_e op_sel,
                                                       input logic const_sel,
                                                       input logic [SCALAR_W-1:0] cval,
                                                       input logic [MAT_W-1:0] a,
                                                       input logic [MAT_W-1:0] b);
  logic [MAT_W-1:0]    res;
  logic [SCALAR_W-1:0] av;
  logic [SCALAR_W-1:0] bv;
  logic [SCALAR_W-1:0] rv;
  res = '0;
  for (int r = 0; r < N_DIM; r++)
  begin
    for (int c = 0; c < N_DIM; c++)
    begin
      av = elem(a, r, c);
      bv = const_sel ? cval : elem(b, r, c);
      case (op_sel)
        mac_pkg::OP_ADD:   rv = av + bv;
        mac_pkg::OP_SUB:   rv = av - bv;
        mac_pkg::OP_EWMUL: rv = av * bv;
        default:           rv = '0;
      endcase
      res[(r*N_DIM + c)*SCALAR_W +: SCALAR_W] = rv;
    end
  end
  return res;
endfunction

// C plus the partial matrix product over the first step_cnt inner indices
function automatic logic [MAT_W-1:0] model_matmul(input logic [STEP_W-1:0] step_cnt,
                                                  input logic [MAT_W-1:0] a,
                                                  input logic [MAT_W-1:0] b,
                                                  input logic [MAT_W-1:0] c_mat);
  logic [MAT_W-1:0]    res;
  logic [SCALAR_W-1:0] acc;
  res = '0;
  for (int i = 0; i < N_DIM; i++)
  begin
    for (int j = 0; j < N_DIM; j++)
    begin
      acc = elem(c_mat, i, j);
      for (int k = 0; k < int'(step_cnt); k++)
        acc = acc + elem(a, i, k) * elem(b, k, j);
      res[(i*N_DIM + j)*SCALAR_W +: SCALAR_W] = acc;
    end
  end
  return res;
endfunction

function automatic logic [N_DIM*N_DIM-1:0] model_mask(input logic [N_DIM-1:0] rows,
                                                      input logic [N_DIM-1:0] cols);
  logic [N_DIM*N_DIM-1:0] m;
  for (int r = 0; r < N_DIM; r++)
  begin
    for (int c = 0; c < N_DIM; c++)
      m[r*N_DIM + c] = rows[r] & cols[c];
  end
  return m;
endfunction

// ***************************************************************************
// Compare tasks
// ***************************************************************************

task automatic check_result(input logic [MAT_W-1:0] got, input logic [MAT_W-1:0] exp,
                            input string what);
  if (got !== exp)
  begin
    for (int r = 0; r < N_DIM; r++)
      for (int c = 0; c < N_DIM; c++)
        if (elem(got, r, c) !== elem(exp, r, c))
          value_error($sformatf("%s result (%0d,%0d) is %0d, expected %0d", what, r, c,
                                $signed(elem(got, r, c)), $signed(elem(exp, r, c))));
  end
endtask

task automatic check_mask(input logic [N_DIM*N_DIM-1:0] got,
                          input logic [N_DIM*N_DIM-1:0] exp, input string what);
  if (got !== exp)
    value_error($sformatf("%s write mask is %h, expected %h", what, got, exp));
endtask

`endif

/* tb/tb_mac_matrix_unit.sv */
`timescale 1ns/10ps

module tb_mac_matrix_unit;

  localparam int N_DIM          = mac_pkg::DEF_N_DIM;
  localparam int SCALAR_W       = mac_pkg::DEF_SCALAR_W;
  localparam int MAT_W          = N_DIM * N_DIM * SCALAR_W;
  localparam int STEP_W         = $clog2(N_DIM + 1);
  localparam int CLK_PERIOD     = 8;
  localparam int TIMEOUT_CYCLES = 50;
  localparam int QUIET_CYCLES   = 2 * N_DIM + 6;
  localparam int NUM_EW         = 60;
  localparam int NUM_MM         = 40;
  localparam int NUM_CLEAR      = 4;

  logic                   clk;
  logic                   rst_n;
  logic                   start;
  logic                   abort_req;
  mac_pkg::mac_op_e       op;
  logic                   use_const;
  logic [N_DIM-1:0]       row_mask;
  logic [N_DIM-1:0]       col_mask;
  logic [STEP_W-1:0]      steps;
  logic [MAT_W-1:0]       mat_a;
  logic [MAT_W-1:0]       mat_b;
  logic [MAT_W-1:0]       mat_c;
  logic [SCALAR_W-1:0]    const_val;
  logic                   busy;
  logic                   done;
  logic [MAT_W-1:0]       result;
  logic [N_DIM*N_DIM-1:0] wr_mask;
  integer                 seed;

  mac_matrix_unit #(.N_DIM(N_DIM), .SCALAR_W(SCALAR_W)) DUT (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_start     (start),
    .i_abort     (abort_req),
    .i_op        (op),
    .i_use_const (use_const),
    .i_row_mask  (row_mask),
    .i_col_mask  (col_mask),
    .i_steps     (steps),
    .i_mat_a     (mat_a),
    .i_mat_b     (mat_b),
    .i_mat_c     (mat_c),
    .i_const     (const_val),
    .o_busy      (busy),
    .o_done      (done),
    .o_result    (result),
    .o_wr_mask   (wr_mask)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  `include "mac_tb_model.svh"

  // ************************************************************************
  // Failure reporting
  // ************************************************************************

  task automatic end_in_failure(input string line);
    $display("%s", line);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic value_error(input string msg);
    end_in_failure($sformatf("** Error at %0d ns: %s", $time, msg));
  endtask

  // ************************************************************************
  // Stimulus driven right after a falling edge
  // ************************************************************************

  task automatic load_operands(input mac_pkg::mac_op_e op_sel, input logic const_sel,
                               input logic [STEP_W-1:0] step_cnt);
    op        = op_sel;
    use_const = const_sel;
    steps     = step_cnt;
    row_mask  = N_DIM'($random(seed));
    col_mask  = N_DIM'($random(seed));
    const_val = SCALAR_W'($random(seed));
    for (int e = 0; e < N_DIM * N_DIM; e++)
    begin
      mat_a[e*SCALAR_W +: SCALAR_W] = SCALAR_W'($random(seed));
      mat_b[e*SCALAR_W +: SCALAR_W] = SCALAR_W'($random(seed));
      mat_c[e*SCALAR_W +: SCALAR_W] = SCALAR_W'($random(seed));
    end
  endtask

  // Counts cycles from the start edge until o_done is seen
  task automatic wait_done(output int cycles);
    cycles = 0;
    while (done !== 1'b1)
    begin
      if (cycles >= TIMEOUT_CYCLES)
        end_in_failure("Timed out waiting for o_done");
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic run_op(input mac_pkg::mac_op_e op_sel, input logic const_sel,
                        input logic [STEP_W-1:0] step_cnt);
    logic [MAT_W-1:0]       exp_result;
    logic [N_DIM*N_DIM-1:0] exp_mask;
    int                     latency;
    load_operands(op_sel, const_sel, step_cnt);
    if (op_sel == mac_pkg::OP_MATMUL)
      exp_result = model_matmul(step_cnt, mat_a, mat_b, mat_c);
    else
      exp_result = model_elementwise(op_sel, const_sel, const_val, mat_a, mat_b);
    exp_mask = model_mask(row_mask, col_mask);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait_done(latency);
    if (op_sel != mac_pkg::OP_MATMUL && latency != 2)
      value_error($sformatf("%s done after %0d cycles, expected 2", op_sel.name(), latency));
    check_result(result, exp_result, op_sel.name());
    check_mask(wr_mask, exp_mask, op_sel.name());
  endtask

  task automatic abort_matmul();
    int cycles;
    load_operands(mac_pkg::OP_MATMUL, 1'b0, STEP_W'(N_DIM));
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    @(negedge clk);
    abort_req = 1'b1;
    @(negedge clk);
    abort_req = 1'b0;
    cycles = 0;
    while (busy !== 1'b0)
    begin
      if (cycles >= TIMEOUT_CYCLES)
        end_in_failure("o_busy stayed high after the abort");
      @(negedge clk);
      cycles++;
    end
    for (int n = 0; n < QUIET_CYCLES; n++)
    begin
      if (done !== 1'b0)
        end_in_failure("o_done appeared after an aborted matmul");
      @(negedge clk);
    end
  endtask

  task automatic pick_ew_op(output mac_pkg::mac_op_e op_sel);
    int sel;
    sel = int'($unsigned($random(seed)) % 3);
    case (sel)
      0:       op_sel = mac_pkg::OP_ADD;
      1:       op_sel = mac_pkg::OP_SUB;
      default: op_sel = mac_pkg::OP_EWMUL;
    endcase
  endtask

  // ************************************************************************
  // Main sequence
  // ************************************************************************

  initial
  begin
    mac_pkg::mac_op_e next_op;
    seed      = 80;
    clk       = 1'b0;
    rst_n     = 1'b0;
    start     = 1'b0;
    abort_req = 1'b0;
    op        = mac_pkg::OP_ADD;
    use_const = 1'b0;
    row_mask  = '0;
    col_mask  = '0;
    steps     = STEP_W'(1);
    mat_a     = '0;
    mat_b     = '0;
    mat_c     = '0;
    const_val = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    if (busy !== 1'b0 || done !== 1'b0)
      value_error("o_busy or o_done not low after reset");
    check_mask(wr_mask, '0, "Reset");

    for (int n = 0; n < NUM_EW; n++)
    begin
      pick_ew_op(next_op);
      run_op(next_op, 1'($random(seed)), STEP_W'(1));
    end

    // Inner step count from 1 to N_DIM
    for (int n = 0; n < NUM_MM; n++)
      run_op(mac_pkg::OP_MATMUL, 1'b0, STEP_W'(1 + $unsigned($random(seed)) % N_DIM));

    for (int n = 0; n < NUM_CLEAR; n++)
      run_op(mac_pkg::OP_CLEAR, 1'($random(seed)), STEP_W'(1));

    abort_matmul();
    run_op(mac_pkg::OP_ADD, 1'b0, STEP_W'(1));

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* verilog/mac_decoder.sv */
`timescale 1ns/10ps

module mac_decoder
(
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_start,
  input  logic               i_abort,
  input  mac_pkg::mac_op_e   i_op,
  input  logic               i_mm_last,
  output logic               o_busy,
  output logic               o_lane_en,
  output logic               o_lane_sub,
  output logic               o_lane_mul,
  output logic               o_mm_start,
  output mac_pkg::mac_src_e  o_src,
  output logic               o_fin
);

  mac_pkg::mac_state_e state_q;
  mac_pkg::mac_op_e    op_q;
  logic                phase_q;
  logic                run;
  logic                accept;
  logic                is_matmul;
  logic                is_ew;

  assign run       = (state_q == mac_pkg::ST_RUN);
  assign accept    = i_start && !i_abort && (state_q == mac_pkg::ST_IDLE);
  assign is_matmul = (op_q == mac_pkg::OP_MATMUL);
  assign is_ew     = op_q inside {mac_pkg::OP_ADD, mac_pkg::OP_SUB, mac_pkg::OP_EWMUL};

  // phase_q marks the cycle after the lanes were loaded
  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      state_q <= mac_pkg::ST_IDLE;
      op_q    <= mac_pkg::OP_ADD;
      phase_q <= 1'b0;
    end
    else if (i_abort)
    begin
      state_q <= mac_pkg::ST_IDLE;
      phase_q <= 1'b0;
    end
    else if (accept)
    begin
      state_q <= mac_pkg::ST_RUN;
      op_q    <= i_op;
      phase_q <= 1'b0;
    end
    else if (run)
    begin
      phase_q <= 1'b1;
      if (o_fin)
        state_q <= mac_pkg::ST_IDLE;
    end
  end

  // Lanes load once for elementwise ops, every cycle during a matmul
  assign o_lane_en  = run && (is_matmul || (is_ew && !phase_q));
  assign o_lane_sub = run && (op_q == mac_pkg::OP_SUB);
  assign o_lane_mul = (op_q == mac_pkg::OP_EWMUL) || is_matmul;
  assign o_mm_start = accept && (i_op == mac_pkg::OP_MATMUL);
  assign o_fin      = run && (is_matmul ? i_mm_last : phase_q);
  assign o_busy     = run;

  always_comb
  begin
    case (op_q)
      mac_pkg::OP_ADD,
      mac_pkg::OP_SUB:    o_src = mac_pkg::SRC_ADD;
      mac_pkg::OP_EWMUL:  o_src = mac_pkg::SRC_MUL;
      mac_pkg::OP_MATMUL: o_src = mac_pkg::SRC_ACC;
      default:            o_src = mac_pkg::SRC_ZERO;
    endcase
  end

endmodule

/* verilog/mac_lane_array.sv */
`timescale 1ns/10ps

module mac_lane_array
#(
  parameter int N_DIM    = 4,
  parameter int SCALAR_W = 8
)
(
  i_clk,
  i_rst_n,
  i_lane_en,
  i_lane_sub,
  i_lane_mul,
  i_mm_active,
  i_mm_k,
  i_use_const,
  i_const,
  i_mat_a,
  i_mat_b,
  o_sum,
  o_prod
);

  localparam int MAT_W = N_DIM * N_DIM * SCALAR_W;
  localparam int K_W   = (N_DIM > 1) ? $clog2(N_DIM) : 1;

  input  logic                i_clk;
  input  logic                i_rst_n;
  input  logic                i_lane_en;
  input  logic                i_lane_sub;
  input  logic                i_lane_mul;
  input  logic                i_mm_active;
  input  logic [K_W-1:0]      i_mm_k;
  input  logic                i_use_const;
  input  logic [SCALAR_W-1:0] i_const;
  input  logic [MAT_W-1:0]    i_mat_a;
  input  logic [MAT_W-1:0]    i_mat_b;
  output logic [MAT_W-1:0]    o_sum;
  output logic [MAT_W-1:0]    o_prod;

  logic [MAT_W-1:0] sum_d;
  logic [MAT_W-1:0] prod_d;

  // Element (r,c) sits at bit (r*N_DIM + c)*SCALAR_W, row 0 in the low bits
  for (genvar r = 0; r < N_DIM; r++)
  begin : g_row
    for (genvar c = 0; c < N_DIM; c++)
    begin : g_col
      logic [SCALAR_W-1:0] a_op;
      logic [SCALAR_W-1:0] b_raw;
      logic [SCALAR_W-1:0] b_op;

      // Matmul walks row r of A against column c of B
      assign a_op  = i_mm_active ? i_mat_a[(r*N_DIM + int'(i_mm_k))*SCALAR_W +: SCALAR_W]
                                 : i_mat_a[(r*N_DIM + c)*SCALAR_W +: SCALAR_W];
      assign b_raw = i_mm_active ? i_mat_b[(int'(i_mm_k)*N_DIM + c)*SCALAR_W +: SCALAR_W]
                                 : i_mat_b[(r*N_DIM + c)*SCALAR_W +: SCALAR_W];
      assign b_op  = i_use_const ? i_const : b_raw;

      // Low bits only, so two's complement wrap needs no sign handling
      assign sum_d[(r*N_DIM + c)*SCALAR_W +: SCALAR_W]  = i_lane_sub ? (a_op - b_op)
                                                                     : (a_op + b_op);
      assign prod_d[(r*N_DIM + c)*SCALAR_W +: SCALAR_W] = a_op * b_op;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_sum  <= '0;
      o_prod <= '0;
    end
    else if (i_lane_en)
    begin
      if (i_lane_mul)
        o_prod <= prod_d;
      else
        o_sum <= sum_d;
    end
  end

endmodule

/* verilog/mac_matmul_seq.sv */
`timescale 1ns/10ps

module mac_matmul_seq
#(
  parameter int N_DIM    = 4,
  parameter int SCALAR_W = 8
)
(
  i_clk,
  i_rst_n,
  i_mm_start,
  i_abort,
  i_steps,
  i_mat_c,
  i_prod,
  o_mm_active,
  o_mm_k,
  o_mm_last,
  o_acc
);

  localparam int MAT_W  = N_DIM * N_DIM * SCALAR_W;
  localparam int K_W    = (N_DIM > 1) ? $clog2(N_DIM) : 1;
  localparam int STEP_W = $clog2(N_DIM + 1);

  input  logic              i_clk;
  input  logic              i_rst_n;
  input  logic              i_mm_start;
  input  logic              i_abort;
  input  logic [STEP_W-1:0] i_steps;
  input  logic [MAT_W-1:0]  i_mat_c;
  input  logic [MAT_W-1:0]  i_prod;
  output logic              o_mm_active;
  output logic [K_W-1:0]    o_mm_k;
  output logic              o_mm_last;
  output logic [MAT_W-1:0]  o_acc;

  logic [STEP_W-1:0] steps_q;
  logic [STEP_W-1:0] k_inc;
  logic              last_step;
  logic              valid_q;
  logic              tail_q;
  logic [MAT_W-1:0]  acc_sum;

  assign k_inc     = STEP_W'(o_mm_k) + STEP_W'(1);
  assign last_step = (k_inc == steps_q);

  // ************************************************************************
  // Inner index counter, and a valid bit aligned with the product register
  // ************************************************************************

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_mm_active <= 1'b0;
      o_mm_k      <= '0;
      steps_q     <= '0;
      valid_q     <= 1'b0;
      tail_q      <= 1'b0;
      o_mm_last   <= 1'b0;
    end
    else if (i_abort)
    begin
      o_mm_active <= 1'b0;
      valid_q     <= 1'b0;
      tail_q      <= 1'b0;
      o_mm_last   <= 1'b0;
    end
    else if (i_mm_start)
    begin
      o_mm_active <= 1'b1;
      o_mm_k      <= '0;
      steps_q     <= i_steps;
      valid_q     <= 1'b0;
      tail_q      <= 1'b0;
      o_mm_last   <= 1'b0;
    end
    else
    begin
      if (o_mm_active)
      begin
        if (last_step)
          o_mm_active <= 1'b0;
        else
          o_mm_k <= K_W'(k_inc);
      end
      valid_q   <= o_mm_active;
      tail_q    <= o_mm_active && last_step;
      // Final product lands in the accumulator on this same edge
      o_mm_last <= tail_q;
    end
  end

  for (genvar e = 0; e < N_DIM * N_DIM; e++)
  begin : g_acc
    assign acc_sum[e*SCALAR_W +: SCALAR_W] = o_acc[e*SCALAR_W +: SCALAR_W]
                                           + i_prod[e*SCALAR_W +: SCALAR_W];
  end

  // Accumulator starts from C
  always_ff @(posedge i_clk)
  begin
    if (i_mm_start)
      o_acc <= i_mat_c;
    else if (valid_q)
      o_acc <= acc_sum;
  end

endmodule

/* verilog/mac_matrix_unit.sv */
`timescale 1ns/10ps

module mac_matrix_unit
#(
  parameter int N_DIM    = mac_pkg::DEF_N_DIM,
  parameter int SCALAR_W = mac_pkg::DEF_SCALAR_W
)
(
  i_clk,
  i_rst_n,
  i_start,
  i_abort,
  i_op,
  i_use_const,
  i_row_mask,
  i_col_mask,
  i_steps,
  i_mat_a,
  i_mat_b,
  i_mat_c,
  i_const,
  o_busy,
  o_done,
  o_result,
  o_wr_mask
);

  localparam int MAT_W  = N_DIM * N_DIM * SCALAR_W;
  localparam int K_W    = (N_DIM > 1) ? $clog2(N_DIM) : 1;
  localparam int STEP_W = $clog2(N_DIM + 1);

  input  logic                   i_clk;
  input  logic                   i_rst_n;
  input  logic                   i_start;
  input  logic                   i_abort;
  // Start fields and operands are held until o_done
  input  mac_pkg::mac_op_e       i_op;
  input  logic                   i_use_const;
  input  logic [N_DIM-1:0]       i_row_mask;
  input  logic [N_DIM-1:0]       i_col_mask;
  input  logic [STEP_W-1:0]      i_steps;
  input  logic [MAT_W-1:0]       i_mat_a;
  input  logic [MAT_W-1:0]       i_mat_b;
  input  logic [MAT_W-1:0]       i_mat_c;
  input  logic [SCALAR_W-1:0]    i_const;
  output logic                   o_busy;
  output logic                   o_done;
  output logic [MAT_W-1:0]       o_result;
  output logic [N_DIM*N_DIM-1:0] o_wr_mask;

  logic              lane_en;
  logic              lane_sub;
  logic              lane_mul;
  logic              mm_start;
  logic              mm_active;
  logic [K_W-1:0]    mm_k;
  logic              mm_last;
  logic              fin;
  mac_pkg::mac_src_e src;
  logic [MAT_W-1:0]  sum;
  logic [MAT_W-1:0]  prod;
  logic [MAT_W-1:0]  acc;

  mac_decoder u_decoder (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_start    (i_start),
    .i_abort    (i_abort),
    .i_op       (i_op),
    .i_mm_last  (mm_last),
    .o_busy     (o_busy),
    .o_lane_en  (lane_en),
    .o_lane_sub (lane_sub),
    .o_lane_mul (lane_mul),
    .o_mm_start (mm_start),
    .o_src      (src),
    .o_fin      (fin)
  );

  mac_lane_array #(.N_DIM(N_DIM), .SCALAR_W(SCALAR_W)) u_lanes (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_lane_en   (lane_en),
    .i_lane_sub  (lane_sub),
    .i_lane_mul  (lane_mul),
    .i_mm_active (mm_active),
    .i_mm_k      (mm_k),
    .i_use_const (i_use_const),
    .i_const     (i_const),
    .i_mat_a     (i_mat_a),
    .i_mat_b     (i_mat_b),
    .o_sum       (sum),
    .o_prod      (prod)
  );

  mac_matmul_seq #(.N_DIM(N_DIM), .SCALAR_W(SCALAR_W)) u_matmul (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_mm_start  (mm_start),
    .i_abort     (i_abort),
    .i_steps     (i_steps),
    .i_mat_c     (i_mat_c),
    .i_prod      (prod),
    .o_mm_active (mm_active),
    .o_mm_k      (mm_k),
    .o_mm_last   (mm_last),
    .o_acc       (acc)
  );

  mac_writeback #(.N_DIM(N_DIM), .SCALAR_W(SCALAR_W)) u_writeback (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_fin      (fin),
    .i_src      (src),
    .i_row_mask (i_row_mask),
    .i_col_mask (i_col_mask),
    .i_sum      (sum),
    .i_prod     (prod),
    .i_acc      (acc),
    .o_done     (o_done),
    .o_result   (o_result),
    .o_wr_mask  (o_wr_mask)
  );

endmodule

/* verilog/mac_pkg.sv */
package mac_pkg;

  // ************************************************************************
  // Default tile geometry
  // ************************************************************************

  // Elements per row and per column of a tile
  parameter int DEF_N_DIM = 4;

  // Signed element width, all arithmetic wraps to this
  parameter int DEF_SCALAR_W = 8;

  // ************************************************************************
  // Opcodes
  // ************************************************************************

  typedef enum logic [2:0] {
    OP_ADD    = 3'd0,
    OP_SUB    = 3'd1,
    OP_EWMUL  = 3'd2,
    OP_MATMUL = 3'd3,
    OP_CLEAR  = 3'd4
  } mac_op_e;

  // ************************************************************************
  // Control FSM states
  // ************************************************************************

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } mac_state_e;

  // ************************************************************************
  // Result sources for the writeback mux
  // ************************************************************************

  typedef enum logic [1:0] {
    SRC_ADD  = 2'd0,
    SRC_MUL  = 2'd1,
    SRC_ACC  = 2'd2,
    SRC_ZERO = 2'd3
  } mac_src_e;

endpackage

/* verilog/mac_writeback.sv */
`timescale 1ns/10ps

module mac_writeback
#(
  parameter int N_DIM    = 4,
  parameter int SCALAR_W = 8
)
(
  i_clk,
  i_rst_n,
  i_fin,
  i_src,
  i_row_mask,
  i_col_mask,
  i_sum,
  i_prod,
  i_acc,
  o_done,
  o_result,
  o_wr_mask
);

  localparam int MAT_W = N_DIM * N_DIM * SCALAR_W;

  input  logic                     i_clk;
  input  logic                     i_rst_n;
  input  logic                     i_fin;
  input  mac_pkg::mac_src_e        i_src;
  input  logic [N_DIM-1:0]         i_row_mask;
  input  logic [N_DIM-1:0]         i_col_mask;
  input  logic [MAT_W-1:0]         i_sum;
  input  logic [MAT_W-1:0]         i_prod;
  input  logic [MAT_W-1:0]         i_acc;
  output logic                     o_done;
  output logic [MAT_W-1:0]         o_result;
  output logic [N_DIM*N_DIM-1:0]   o_wr_mask;

  logic [MAT_W-1:0]       result_d;
  logic [N_DIM*N_DIM-1:0] mask_d;

  always_comb
  begin
    case (i_src)
      mac_pkg::SRC_ADD: result_d = i_sum;
      mac_pkg::SRC_MUL: result_d = i_prod;
      mac_pkg::SRC_ACC: result_d = i_acc;
      default:          result_d = '0;
    endcase
  end

  // Element write enable, row and column both selected
  for (genvar r = 0; r < N_DIM; r++)
  begin : g_mask_row
    for (genvar c = 0; c < N_DIM; c++)
    begin : g_mask_col
      assign mask_d[r*N_DIM + c] = i_row_mask[r] & i_col_mask[c];
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_done    <= 1'b0;
      o_wr_mask <= '0;
    end
    else
    begin
      o_done <= i_fin;
      if (i_fin)
        o_wr_mask <= mask_d;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_fin)
      o_result <= result_d;
  end

endmodule
